// File: Bender.yml
package:
  name: execute_stage

sources:
  - files:
      - verilog/execute_pkg.sv
      - verilog/ex_operands_if.sv
      - verilog/ex_input_latch.sv
      - verilog/alu_control.sv
      - verilog/operand_select.sv
      - verilog/alu.sv
      - verilog/ex_output_reg.sv
      - verilog/execute_stage.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_execute_stage.sv

// File: execute_stage.f
+incdir+test
verilog/execute_pkg.sv
verilog/ex_operands_if.sv
verilog/ex_input_latch.sv
verilog/alu_control.sv
verilog/operand_select.sv
verilog/alu.sv
verilog/ex_output_reg.sv
verilog/execute_stage.sv
test/tb_execute_stage.sv

// File: test/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Expected {zero, result} of one instruction
function automatic logic [32:0] model_execute(
    input execute_pkg::opcode_t op,
    input execute_pkg::fcode_t  fn,
    input execute_pkg::shamt_t  sh,
    input execute_pkg::imm_t    im,
    input logic [31:0]          rs,
    input logic [31:0]          rt
);
    logic [31:0] sext;
    logic [31:0] res;
    sext = {{16{im[15]}}, im};
    res  = rs + sext;  // ADDI, loads, stores, unknown opcodes
    case (op)
        execute_pkg::RTYPE: begin
            case (fn)
                execute_pkg::SUB, execute_pkg::SUBU: res = rs - rt;
                execute_pkg::AND:  res = rs & rt;
                execute_pkg::OR:   res = rs | rt;
                execute_pkg::XOR:  res = rs ^ rt;
                execute_pkg::NOR:  res = ~(rs | rt);
                execute_pkg::SLT:  res = {31'b0, $signed(rs) < $signed(rt)};
                execute_pkg::SLL:  res = rt << sh;
                execute_pkg::SRL:  res = rt >> sh;
                execute_pkg::SRA:  res = $signed(rt) >>> sh;
                execute_pkg::SLLV: res = rt << rs[4:0];
                execute_pkg::SRLV: res = rt >> rs[4:0];
                execute_pkg::SRAV: res = $signed(rt) >>> rs[4:0];
                default:           res = rs + rt;  // ADD, ADDU, unknown codes
            endcase
        end
        execute_pkg::BEQ:  res = rs - rt;
        execute_pkg::BNE:  res = {31'b0, rs != rt};
        execute_pkg::ANDI: res = rs & {16'h0, im};
        execute_pkg::ORI:  res = rs | {16'h0, im};
        execute_pkg::XORI: res = rs ^ {16'h0, im};
        execute_pkg::LUI:  res = {im, 16'h0};
        execute_pkg::SLTI: res = {31'b0, $signed(rs) < $signed(sext)};
        default: ;
    endcase
    return {res == 32'h0, res};
endfunction

`endif

// File: test/tb_execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

module tb_execute_stage;

    localparam int NB_DATA        = 32;
    localparam int N_STREAM       = 200;
    localparam int TIMEOUT_CYCLES = 4 * N_STREAM + 1200;  // Worst-case stream gaps plus rest

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   valid;
    execute_pkg::opcode_t   opcode;
    execute_pkg::fcode_t    funct;
    execute_pkg::shamt_t    shamt;
    execute_pkg::imm_t      imm;
    execute_pkg::reg_addr_t rd_addr;
    logic [NB_DATA-1:0]     rs_data;
    logic [NB_DATA-1:0]     rt_data;
    logic                   out_valid;
    logic [NB_DATA-1:0]     out_result;
    logic                   out_zero;
    execute_pkg::reg_addr_t out_rd_addr;

    logic [37:0] expected_q [$];  // {rd_addr, zero, result}
    logic [37:0] head;
    int          pass_count  = 0;
    int          fail_count  = 0;
    int          cycle_count = 0;

    `include "tb_ref_model.svh"

    always #4 clk = ~clk;

    execute_stage #(.NB_DATA(NB_DATA)) i_dut (
        .i_clk     (clk),
        .i_reset   (reset),
        .i_valid   (valid),
        .i_opcode  (opcode),
        .i_funct   (funct),
        .i_shamt   (shamt),
        .i_imm     (imm),
        .i_rd_addr (rd_addr),
        .i_rs_data (rs_data),
        .i_rt_data (rt_data),
        .o_valid   (out_valid),
        .o_result  (out_result),
        .o_zero    (out_zero),
        .o_rd_addr (out_rd_addr)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) pass_count++;
        else begin
            fail_count++;
            $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic issue_instr(input execute_pkg::opcode_t op, input execute_pkg::fcode_t fn,
                               input execute_pkg::shamt_t sh, input execute_pkg::imm_t im,
                               input logic [31:0] rs, input logic [31:0] rt);
        logic [32:0] exp_pair;
        logic [31:0] r;
        r        = $urandom();
        exp_pair = model_execute(op, fn, sh, im, rs, rt);
        @(posedge clk);
        valid   <= 1'b1;
        opcode  <= op;
        funct   <= fn;
        shamt   <= sh;
        imm     <= im;
        rs_data <= rs;
        rt_data <= rt;
        rd_addr <= r[4:0];
        expected_q.push_back({r[4:0], exp_pair});
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            valid <= 1'b0;
        end
    endtask

    task automatic end_test(input string name, input int fails_before);
        idle(1);
        while (expected_q.size() != 0) @(negedge clk);
        $display("%s done, %0d failed checks", name, fail_count - fails_before);
    endtask

    // One expected entry popped per o_valid
    always @(negedge clk) begin
        if (out_valid === 1'b1) begin
            assert (expected_q.size() != 0)
            else begin
                fail_count++;
                $display("o_valid seen with no instruction outstanding");
            end
            if (expected_q.size() != 0) begin
                head = expected_q.pop_front();
                check_value("o_result", out_result, head[31:0]);
                check_value("o_zero", {31'b0, out_zero}, {31'b0, head[32]});
                check_value("o_rd_addr", {27'b0, out_rd_addr}, {27'b0, head[37:33]});
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run stopped after %0d cycles without finishing", cycle_count);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic reset_and_latency();
        int fails_before;
        int lat;
        fails_before = fail_count;
        lat          = 0;
        repeat (4) begin
            @(negedge clk);
            check_value("o_valid", {31'b0, out_valid}, 32'd0);
            check_value("o_result", out_result, 32'd0);
            check_value("o_zero", {31'b0, out_zero}, 32'd0);
            check_value("o_rd_addr", {27'b0, out_rd_addr}, 32'd0);
        end
        issue_instr(execute_pkg::ADDI, 6'd0, 5'd0, 16'h0010, 32'h0000_0100, 32'd0);
        do begin
            @(posedge clk);
            valid <= 1'b0;
            lat++;
            @(negedge clk);
        end while (out_valid !== 1'b1 && lat < 8);
        assert (lat == 2)
        else begin
            fail_count++;
            $display("o_valid came %0d edges after the driving edge instead of 2", lat);
        end
        end_test("reset_latency", fails_before);
    endtask

    task automatic rtype_arith();
        execute_pkg::fcode_t functs [9];
        logic [31:0]         edges [5];
        logic [31:0]         r;
        int                  fails_before;
        fails_before = fail_count;
        functs = '{execute_pkg::ADD, execute_pkg::ADDU, execute_pkg::SUB, execute_pkg::SUBU,
                   execute_pkg::AND, execute_pkg::OR, execute_pkg::XOR, execute_pkg::NOR,
                   execute_pkg::SLT};
        edges  = '{32'h0, 32'h1, 32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff};
        foreach (functs[f]) begin
            for (int i = 0; i < 5; i++) begin
                r = $urandom();
                issue_instr(execute_pkg::RTYPE, functs[f], r[4:0], r[20:5],
                            edges[i], edges[(i + 3) % 5]);
                issue_instr(execute_pkg::RTYPE, functs[f], r[4:0], r[20:5],
                            $urandom(), $urandom());
            end
        end
        end_test("rtype_arith", fails_before);
    endtask

    task automatic shift_ops();
        execute_pkg::fcode_t functs [6];
        execute_pkg::shamt_t amounts [4];
        logic [31:0]         r;
        int                  fails_before;
        fails_before = fail_count;
        functs  = '{execute_pkg::SLL, execute_pkg::SRL, execute_pkg::SRA,
                    execute_pkg::SLLV, execute_pkg::SRLV, execute_pkg::SRAV};
        amounts = '{5'd0, 5'd1, 5'd16, 5'd31};
        foreach (functs[f]) begin
            foreach (amounts[a]) begin
                r = $urandom();
                // shamt and rs[4:0] differ so the wrong source shows up
                issue_instr(execute_pkg::RTYPE, functs[f], amounts[a], r[15:0],
                            {r[31:5], amounts[(a + 1) % 4]}, 32'h8765_4321);
                issue_instr(execute_pkg::RTYPE, functs[f], amounts[a], r[15:0],
                            {r[31:5], amounts[(a + 1) % 4]}, $urandom());
            end
        end
        end_test("shift_ops", fails_before);
    endtask

    task automatic immediate_forms();
        execute_pkg::opcode_t ops [13];
        execute_pkg::imm_t    imms [4];
        logic [31:0]          r;
        int                   fails_before;
        fails_before = fail_count;
        ops  = '{execute_pkg::ADDI, execute_pkg::SLTI, execute_pkg::ANDI, execute_pkg::ORI,
                 execute_pkg::XORI, execute_pkg::LUI, execute_pkg::LB, execute_pkg::LBU,
                 execute_pkg::LH, execute_pkg::LHU, execute_pkg::LW, execute_pkg::LWU,
                 execute_pkg::SW};
        imms = '{16'hffff, 16'h8000, 16'h7fff, 16'ha5a5};
        foreach (ops[o]) begin
            foreach (imms[i]) begin
                r = $urandom();
                issue_instr(ops[o], r[5:0], r[10:6], imms[i],
                            (i % 2 == 1) ? r : 32'h0000_0004, 32'hdead_beef);
            end
        end
        end_test("immediate_forms", fails_before);
    endtask

    task automatic branch_compares();
        logic [31:0] r;
        int          fails_before;
        fails_before = fail_count;
        repeat (4) begin
            r = $urandom();
            issue_instr(execute_pkg::BEQ, 6'd0, 5'd0, r[15:0], r, r);
            issue_instr(execute_pkg::BEQ, 6'd0, 5'd0, r[15:0], r, ~r);
            issue_instr(execute_pkg::BNE, 6'd0, 5'd0, r[15:0], r, r);
            issue_instr(execute_pkg::BNE, 6'd0, 5'd0, r[15:0], r, r ^ 32'h1);
        end
        end_test("branch_compares", fails_before);
    endtask

    task automatic random_stream();
        execute_pkg::opcode_t ops [17];
        execute_pkg::opcode_t op;
        logic [31:0]          r;
        int                   fails_before;
        fails_before = fail_count;
        ops = '{execute_pkg::RTYPE, execute_pkg::RTYPE, execute_pkg::ADDI, execute_pkg::ANDI,
                execute_pkg::ORI, execute_pkg::XORI, execute_pkg::LUI, execute_pkg::SLTI,
                execute_pkg::BEQ, execute_pkg::BNE, execute_pkg::LB, execute_pkg::LBU,
                execute_pkg::LH, execute_pkg::LHU, execute_pkg::LW, execute_pkg::LWU,
                execute_pkg::SW};
        repeat (N_STREAM) begin
            r  = $urandom();
            op = (r[31:29] == 3'd0) ? r[5:0] : ops[r[28:24] % 17];  // Some unknown opcodes
            issue_instr(op, r[11:6], r[16:12], r[23:8], $urandom(), $urandom());
            idle($urandom_range(0, 3));
        end
        end_test("random_stream", fails_before);
    endtask

    initial begin
        void'($urandom(43145));
        reset   = 1'b1;
        valid   = 1'b0;
        opcode  = '0;
        funct   = '0;
        shamt   = '0;
        imm     = '0;
        rd_addr = '0;
        rs_data = '0;
        rt_data = '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        reset_and_latency();
        rtype_arith();
        shift_ops();
        immediate_forms();
        branch_compares();
        random_stream();
        $display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu #(
    parameter int NB_DATA = execute_pkg::NB_DATA
) (
    input  execute_pkg::alu_op_e i_alu_operation,
    input  wire [NB_DATA-1:0]    i_data_a,
    input  wire [NB_DATA-1:0]    i_data_b,
    output logic [NB_DATA-1:0]   o_result
);

    localparam int NB_SHIFT = execute_pkg::NB_SHAMT;

    logic [NB_SHIFT-1:0] shift_amount;

    assign shift_amount = i_data_a[NB_SHIFT-1:0];  // Low bits of A only

    always_comb begin
        case (i_alu_operation)
            execute_pkg::ALU_ADD: o_result = i_data_a + i_data_b;
            execute_pkg::ALU_SUB: o_result = i_data_a - i_data_b;
            execute_pkg::ALU_AND: o_result = i_data_a & i_data_b;
            execute_pkg::ALU_OR:  o_result = i_data_a | i_data_b;
            execute_pkg::ALU_XOR: o_result = i_data_a ^ i_data_b;
            execute_pkg::ALU_NOR: o_result = ~(i_data_a | i_data_b);
            execute_pkg::ALU_SLT: begin
                o_result = {{(NB_DATA-1){1'b0}}, $signed(i_data_a) < $signed(i_data_b)};
            end
            execute_pkg::ALU_SLL: o_result = i_data_b << shift_amount;
            execute_pkg::ALU_SRL: o_result = i_data_b >> shift_amount;
            execute_pkg::ALU_SRA: o_result = $signed(i_data_b) >>> shift_amount;
            execute_pkg::ALU_LUI: o_result = i_data_b << 16;  // Immediate to upper half
            execute_pkg::ALU_BNE: begin
                o_result = {{(NB_DATA-1){1'b0}}, i_data_a != i_data_b};
            end
            default:              o_result = i_data_a + i_data_b;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/alu_control.sv
`timescale 1ns/100ps
`default_nettype none

module alu_control (
    ex_operands_if.dst           i_ops,
    output execute_pkg::alu_op_e o_alu_operation,
    output logic                 o_shamt_ctrl
);

    always_comb begin
        o_alu_operation = execute_pkg::ALU_ADD;
        o_shamt_ctrl    = 1'b0;  // Operand A from rs unless a fixed shift

        case (i_ops.opcode)
            execute_pkg::RTYPE: begin
                case (i_ops.funct)
                    execute_pkg::ADD,
                    execute_pkg::ADDU: begin
                        o_alu_operation = execute_pkg::ALU_ADD;
                    end
                    execute_pkg::SUB,
                    execute_pkg::SUBU: begin
                        o_alu_operation = execute_pkg::ALU_SUB;
                    end
                    execute_pkg::AND:  o_alu_operation = execute_pkg::ALU_AND;
                    execute_pkg::OR:   o_alu_operation = execute_pkg::ALU_OR;
                    execute_pkg::XOR:  o_alu_operation = execute_pkg::ALU_XOR;
                    execute_pkg::NOR:  o_alu_operation = execute_pkg::ALU_NOR;
                    execute_pkg::SLT:  o_alu_operation = execute_pkg::ALU_SLT;
                    execute_pkg::SLL: begin
                        o_alu_operation = execute_pkg::ALU_SLL;
                        o_shamt_ctrl    = 1'b1;  // Shift by instruction shamt
                    end
                    execute_pkg::SRL: begin
                        o_alu_operation = execute_pkg::ALU_SRL;
                        o_shamt_ctrl    = 1'b1;
                    end
                    execute_pkg::SRA: begin
                        o_alu_operation = execute_pkg::ALU_SRA;
                        o_shamt_ctrl    = 1'b1;
                    end
                    execute_pkg::SLLV: o_alu_operation = execute_pkg::ALU_SLL;  // Shift by rs
                    execute_pkg::SRLV: o_alu_operation = execute_pkg::ALU_SRL;
                    execute_pkg::SRAV: o_alu_operation = execute_pkg::ALU_SRA;
                    default: begin
                        o_alu_operation = execute_pkg::ALU_ADD;
                        o_shamt_ctrl    = 1'b0;
                    end
                endcase
            end
            execute_pkg::ADDI,
            execute_pkg::LB,
            execute_pkg::LBU,
            execute_pkg::LH,
            execute_pkg::LHU,
            execute_pkg::LW,
            execute_pkg::LWU,
            execute_pkg::SW: begin
                o_alu_operation = execute_pkg::ALU_ADD;  // Base plus offset
            end
            execute_pkg::BEQ:  o_alu_operation = execute_pkg::ALU_SUB;  // Zero flag on equal
            execute_pkg::BNE:  o_alu_operation = execute_pkg::ALU_BNE;
            execute_pkg::ANDI: o_alu_operation = execute_pkg::ALU_AND;
            execute_pkg::ORI:  o_alu_operation = execute_pkg::ALU_OR;
            execute_pkg::XORI: o_alu_operation = execute_pkg::ALU_XOR;
            execute_pkg::LUI:  o_alu_operation = execute_pkg::ALU_LUI;
            execute_pkg::SLTI: o_alu_operation = execute_pkg::ALU_SLT;
            default: begin
                o_alu_operation = execute_pkg::ALU_ADD;
                o_shamt_ctrl    = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/ex_input_latch.sv
`timescale 1ns/100ps
`default_nettype none

module ex_input_latch #(
    parameter int NB_DATA = execute_pkg::NB_DATA
) (
    input  wire                    i_clk,
    input  wire                    i_reset,
    input  wire                    i_valid,
    input  execute_pkg::opcode_t   i_opcode,
    input  execute_pkg::fcode_t    i_funct,
    input  execute_pkg::shamt_t    i_shamt,
    input  execute_pkg::imm_t      i_imm,
    input  execute_pkg::reg_addr_t i_rd_addr,
    input  wire [NB_DATA-1:0]      i_rs_data,
    input  wire [NB_DATA-1:0]      i_rt_data,
    ex_operands_if.src             o_ops
);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_ops.valid <= 1'b0;
        end else begin
            o_ops.valid <= i_valid;  // One strobe per accepted instruction
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            o_ops.opcode  <= i_opcode;
            o_ops.funct   <= i_funct;
            o_ops.shamt   <= i_shamt;
            o_ops.imm     <= i_imm;
            o_ops.rs_data <= i_rs_data;
            o_ops.rt_data <= i_rt_data;
            o_ops.rd_addr <= i_rd_addr;
        end
    end

endmodule

`default_nettype wire

// File: verilog/ex_operands_if.sv
`timescale 1ns/100ps
`default_nettype none

interface ex_operands_if #(
    parameter int NB_DATA = execute_pkg::NB_DATA
);
    logic                   valid;
    execute_pkg::opcode_t   opcode;
    execute_pkg::fcode_t    funct;
    execute_pkg::shamt_t    shamt;
    execute_pkg::imm_t      imm;
    logic [NB_DATA-1:0]     rs_data;
    logic [NB_DATA-1:0]     rt_data;
    execute_pkg::reg_addr_t rd_addr;  // Destination picked in decode

    modport src (
        output valid, opcode, funct, shamt, imm, rs_data, rt_data, rd_addr
    );

    modport dst (
        input valid, opcode, funct, shamt, imm, rs_data, rt_data, rd_addr
    );

endinterface

`default_nettype wire

// File: verilog/ex_output_reg.sv
`timescale 1ns/100ps
`default_nettype none

module ex_output_reg #(
    parameter int NB_DATA = execute_pkg::NB_DATA
) (
    input  wire                     i_clk,
    input  wire                     i_reset,
    ex_operands_if.dst              i_ops,
    input  wire [NB_DATA-1:0]       i_result,
    output logic                    o_valid,
    output logic [NB_DATA-1:0]      o_result,
    output logic                    o_zero,
    output execute_pkg::reg_addr_t  o_rd_addr
);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_valid   <= 1'b0;
            o_result  <= '0;
            o_zero    <= 1'b0;
            o_rd_addr <= '0;
        end else begin
            o_valid <= i_ops.valid;
            if (i_ops.valid) begin
                o_result  <= i_result;
                o_zero    <= (i_result == '0);  // Taken BEQ compare
                o_rd_addr <= i_ops.rd_addr;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/execute_pkg.sv
`default_nettype none

package execute_pkg;

    localparam int NB_DATA     = 32;
    localparam int NB_OPCODE   = 6;
    localparam int NB_FCODE    = 6;
    localparam int NB_SHAMT    = 5;
    localparam int NB_IMM      = 16;
    localparam int NB_REG_ADDR = 5;

    typedef logic [NB_OPCODE-1:0]   opcode_t;
    typedef logic [NB_FCODE-1:0]    fcode_t;
    typedef logic [NB_SHAMT-1:0]    shamt_t;
    typedef logic [NB_IMM-1:0]      imm_t;
    typedef logic [NB_REG_ADDR-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_NOR = 4'd5,
        ALU_SLT = 4'd6,
        ALU_SLL = 4'd7,
        ALU_SRL = 4'd8,
        ALU_SRA = 4'd9,
        ALU_LUI = 4'd10,
        ALU_BNE = 4'd11
    } alu_op_e;

    // Opcodes
    localparam opcode_t RTYPE = 6'b000000;
    localparam opcode_t ADDI  = 6'b001000;
    localparam opcode_t ANDI  = 6'b001100;
    localparam opcode_t ORI   = 6'b001101;
    localparam opcode_t XORI  = 6'b001110;
    localparam opcode_t LUI   = 6'b001111;
    localparam opcode_t SLTI  = 6'b001010;
    localparam opcode_t BEQ   = 6'b000100;
    localparam opcode_t BNE   = 6'b000101;
    localparam opcode_t LB    = 6'b100000;
    localparam opcode_t LBU   = 6'b100100;
    localparam opcode_t LH    = 6'b100001;
    localparam opcode_t LHU   = 6'b100101;
    localparam opcode_t LW    = 6'b100011;
    localparam opcode_t LWU   = 6'b100111;
    localparam opcode_t SW    = 6'b101011;

    // R-type function codes
    localparam fcode_t ADD  = 6'b100000;
    localparam fcode_t ADDU = 6'b100001;
    localparam fcode_t SUB  = 6'b100010;
    localparam fcode_t SUBU = 6'b100011;
    localparam fcode_t AND  = 6'b100100;
    localparam fcode_t OR   = 6'b100101;
    localparam fcode_t XOR  = 6'b100110;
    localparam fcode_t NOR  = 6'b100111;
    localparam fcode_t SLT  = 6'b101010;
    localparam fcode_t SLL  = 6'b000000;
    localparam fcode_t SRL  = 6'b000010;
    localparam fcode_t SRA  = 6'b000011;
    localparam fcode_t SLLV = 6'b000100;
    localparam fcode_t SRLV = 6'b000110;
    localparam fcode_t SRAV = 6'b000111;

endpackage

`default_nettype wire

// File: verilog/execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

module execute_stage #(
    parameter int NB_DATA = execute_pkg::NB_DATA
) (
    input  wire                     i_clk,
    input  wire                     i_reset,
    input  wire                     i_valid,
    input  execute_pkg::opcode_t    i_opcode,
    input  execute_pkg::fcode_t     i_funct,
    input  execute_pkg::shamt_t     i_shamt,
    input  execute_pkg::imm_t       i_imm,
    input  execute_pkg::reg_addr_t  i_rd_addr,
    input  wire [NB_DATA-1:0]       i_rs_data,
    input  wire [NB_DATA-1:0]       i_rt_data,
    output logic                    o_valid,
    output logic [NB_DATA-1:0]      o_result,
    output logic                    o_zero,
    output execute_pkg::reg_addr_t  o_rd_addr
);

    execute_pkg::alu_op_e alu_op;
    logic                 shamt_sel;
    logic [NB_DATA-1:0]   alu_a;
    logic [NB_DATA-1:0]   alu_b;
    logic [NB_DATA-1:0]   alu_result;

    ex_operands_if #(.NB_DATA(NB_DATA)) ops_if ();

    ex_input_latch #(.NB_DATA(NB_DATA)) u_input_latch (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_valid   (i_valid),
        .i_opcode  (i_opcode),
        .i_funct   (i_funct),
        .i_shamt   (i_shamt),
        .i_imm     (i_imm),
        .i_rd_addr (i_rd_addr),
        .i_rs_data (i_rs_data),
        .i_rt_data (i_rt_data),
        .o_ops     (ops_if.src)
    );

    alu_control u_alu_control (
        .i_ops           (ops_if.dst),
        .o_alu_operation (alu_op),
        .o_shamt_ctrl    (shamt_sel)
    );

    operand_select #(.NB_DATA(NB_DATA)) u_operand_select (
        .i_ops        (ops_if.dst),
        .i_shamt_ctrl (shamt_sel),
        .o_alu_a      (alu_a),
        .o_alu_b      (alu_b)
    );

    alu #(.NB_DATA(NB_DATA)) u_alu (
        .i_alu_operation (alu_op),
        .i_data_a        (alu_a),
        .i_data_b        (alu_b),
        .o_result        (alu_result)
    );

    ex_output_reg #(.NB_DATA(NB_DATA)) u_output_reg (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_ops     (ops_if.dst),
        .i_result  (alu_result),
        .o_valid   (o_valid),
        .o_result  (o_result),
        .o_zero    (o_zero),
        .o_rd_addr (o_rd_addr)
    );

endmodule

`default_nettype wire

// File: verilog/operand_select.sv
`timescale 1ns/100ps
`default_nettype none

module operand_select #(
    parameter int NB_DATA = execute_pkg::NB_DATA
) (
    ex_operands_if.dst         i_ops,
    input  wire                i_shamt_ctrl,
    output logic [NB_DATA-1:0] o_alu_a,
    output logic [NB_DATA-1:0] o_alu_b
);

    localparam int NB_SHAMT_PAD = NB_DATA - execute_pkg::NB_SHAMT;
    localparam int NB_IMM_PAD   = NB_DATA - execute_pkg::NB_IMM;

    logic [NB_DATA-1:0] shamt_ext;
    logic [NB_DATA-1:0] imm_zext;
    logic [NB_DATA-1:0] imm_sext;

    assign shamt_ext = {{NB_SHAMT_PAD{1'b0}}, i_ops.shamt};
    assign imm_zext  = {{NB_IMM_PAD{1'b0}}, i_ops.imm};
    assign imm_sext  = {{NB_IMM_PAD{i_ops.imm[execute_pkg::NB_IMM-1]}}, i_ops.imm};

    assign o_alu_a = i_shamt_ctrl ? shamt_ext : i_ops.rs_data;

    always_comb begin
        case (i_ops.opcode)
            execute_pkg::RTYPE,
            execute_pkg::BEQ,
            execute_pkg::BNE: begin
                o_alu_b = i_ops.rt_data;
            end
            execute_pkg::ANDI,
            execute_pkg::ORI,
            execute_pkg::XORI,
            execute_pkg::LUI: begin
                o_alu_b = imm_zext;  // Logical immediates are unsigned
            end
            default: begin
                o_alu_b = imm_sext;  // Arithmetic, compare and address offsets
            end
        endcase
    end

endmodule

`default_nettype wire
